// ==== src.f ====
+incdir+include
source/mips_pkg.sv
source/mips_fetch.sv
source/mips_decode.sv
source/mips_execute.sv
source/mips_memory.sv
source/mips_top.sv
verification/mips_assertions.sv
verification/mips_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MIPS pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module mips_tb \
        -f src.f -o mips_sim; then
    echo "Build failed"
    exit 1
fi

if ! out=$(./obj_dir/mips_sim); then
    echo "$out"
    echo "Simulation exited with an error"
    exit 1
fi

echo "$out"

if echo "$out" | grep -qx ">>> PASS"; then
    exit 0
fi
exit 1

// ==== verification/mips_tb.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_tb;
    import mips_pkg::*;

    localparam int NUM_TESTS = 4;
    localparam int IMEM_AW   = $clog2(`MIPS_IMEM_WORDS);

    logic                      i_clk;
    logic                      i_reset;
    logic                      i_imem_we;
    logic [IMEM_AW-1:0]        i_imem_addr;
    logic [`MIPS_XLEN-1:0]     i_imem_data;
    logic [`MIPS_REG_BITS-1:0] i_reg_sel;
    logic [`MIPS_XLEN-1:0]     o_pc;
    logic [`MIPS_XLEN-1:0]     o_reg_data;
    logic                      o_halted;

    logic [`MIPS_XLEN-1:0] progs [NUM_TESTS][`MIPS_IMEM_WORDS];
    int                    lens [NUM_TESTS];
    string                 names [NUM_TESTS];
    logic [`MIPS_XLEN-1:0] exp_regs [32];
    logic [`MIPS_XLEN-1:0] exp_pc;
    logic [`MIPS_XLEN-1:0] ref_dmem [`MIPS_DMEM_WORDS];
    string                 cur_name;
    int                    mismatches;
    int                    other_errors;
    int                    cycles;
    int                    cycle_limit;
    logic                  compare_req;

    mips_top mips_top_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_reg_sel   (i_reg_sel),
        .o_pc        (o_pc),
        .o_reg_data  (o_reg_data),
        .o_halted    (o_halted)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    function automatic logic [31:0] enc_r(funct_e f, logic [4:0] rd, logic [4:0] rs,
                                          logic [4:0] rt, logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, f};
    endfunction

    function automatic logic [31:0] enc_i(opcode_e op, logic [4:0] rt, logic [4:0] rs,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(1 + $urandom % 31);
    endfunction

    task automatic emit(input int t, input logic [31:0] word);
        progs[t][lens[t]] = word;
        lens[t]++;
    endtask

    function automatic logic [31:0] rand_alu(logic [4:0] rd, logic [4:0] rs, logic [4:0] rt);
        case ($urandom % 7)
            0: return enc_r(F_ADDU, rd, rs, rt, 5'd0);
            1: return enc_r(F_SUBU, rd, rs, rt, 5'd0);
            2: return enc_r(F_AND, rd, rs, rt, 5'd0);
            3: return enc_r(F_OR, rd, rs, rt, 5'd0);
            4: return enc_r(F_SLT, rd, rs, rt, 5'd0);
            5: return enc_r(F_SLL, rd, 5'd0, rt, 5'($urandom));
            default: return enc_i(OP_ADDI, rd, rs, 16'($urandom));
        endcase
    endfunction

    // Every test starts by giving all registers a known value
    task automatic build_programs();
        logic [4:0] d1, d2, d, a, b;
        logic [15:0] off;
        for (int t = 0; t < NUM_TESTS; t++) begin
            lens[t] = 0;
            for (int r = 1; r < 32; r++)
                emit(t, enc_i(OP_ADDI, 5'(r), 5'd0, 16'($urandom)));
        end
        names[0] = "independent";
        for (int i = 0; i < 6; i++) begin
            emit(0, rand_alu(rand_reg(), rand_reg(), rand_reg()));
            repeat (3) emit(0, 32'h0);
        end
        names[1] = "forwarding";
        d1 = rand_reg();
        d2 = rand_reg();
        for (int i = 0; i < 12; i++) begin
            d = rand_reg();
            if (i % 3 == 2)
                emit(1, enc_r(F_SLL, d, 5'd0, d1, 5'($urandom)));
            else
                emit(1, rand_alu(d, d1, d2));
            d2 = d1;
            d1 = d;
        end
        names[2] = "load_store";
        for (int i = 0; i < 4; i++) begin
            off = 16'(($urandom % `MIPS_DMEM_WORDS) * 4);
            a = rand_reg();
            b = rand_reg();
            emit(2, enc_i(OP_SW, rand_reg(), 5'd0, off));
            emit(2, enc_i(OP_LW, a, 5'd0, off));
            emit(2, enc_r(F_ADDU, b, a, rand_reg(), 5'd0));
        end
        names[3] = "branch";
        a = rand_reg();
        do b = rand_reg(); while (b == a);
        emit(3, enc_i(OP_ADDI, a, 5'd0, 16'($urandom)));
        emit(3, enc_i(OP_ADDI, b, a, 16'd1));
        emit(3, enc_i(OP_BEQ, a, a, 16'd3));
        repeat (3) emit(3, enc_i(OP_ADDI, rand_reg(), 5'd0, 16'($urandom)));
        emit(3, enc_i(OP_BEQ, b, a, 16'd3));
        repeat (3) emit(3, enc_i(OP_ADDI, rand_reg(), 5'd0, 16'($urandom)));
        emit(3, enc_r(F_ADDU, rand_reg(), a, b, 5'd0));
        for (int t = 0; t < NUM_TESTS; t++)
            emit(t, {OP_HALT, 26'd0});
    endtask

    // Sequential ISA model, one instruction at a time
    function automatic void mips_ref(input int t);
        logic [31:0] pc, w, imm, addr, va, vb, res;
        logic [4:0]  rs, rt, rd, sh;
        for (int r = 0; r < 32; r++)
            exp_regs[r] = '0;
        pc = '0;
        exp_pc = '0;
        for (int step = 0; step < 1000; step++) begin
            w    = progs[t][pc[IMEM_AW+1:2]];
            rs   = w[25:21];
            rt   = w[20:16];
            rd   = w[15:11];
            sh   = w[10:6];
            imm  = {{16{w[15]}}, w[15:0]};
            va   = exp_regs[rs];
            vb   = exp_regs[rt];
            addr = va + imm;
            res  = '0;
            pc   = pc + 4;
            case (opcode_e'(w[31:26]))
                OP_RTYPE: begin
                    case (funct_e'(w[5:0]))
                        F_SLL:  res = vb << sh;
                        F_SUBU: res = va - vb;
                        F_AND:  res = va & vb;
                        F_OR:   res = va | vb;
                        F_SLT:  res = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
                        default: res = va + vb;
                    endcase
                    exp_regs[rd] = res;
                end
                OP_ADDI: exp_regs[rt] = addr;
                OP_LW:   exp_regs[rt] = ref_dmem[addr[7:2]];
                OP_SW:   ref_dmem[addr[7:2]] = vb;
                OP_BEQ: begin
                    if (va == vb)
                        pc = pc + (imm << 2);
                end
                OP_HALT: begin
                    exp_pc = pc;
                    break;
                end
                default: ;
            endcase
            exp_regs[0] = '0;
        end
    endfunction

    task automatic check_reg(input string name, input int idx,
                             input logic [`MIPS_XLEN-1:0] expected,
                             input logic [`MIPS_XLEN-1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch %s r%0d: expected %h, actual %h", name, idx, expected, actual);
        end
    endtask

    task automatic check_pc(input string name, input logic [`MIPS_XLEN-1:0] expected,
                            input logic [`MIPS_XLEN-1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch %s pc: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    endtask

    always @(posedge i_clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            other_errors++;
            $display("Timeout: the core never halted within %0d cycles", cycle_limit);
            print_counts();
            $display(">>> FAIL");
            $finish;
        end
    end

    // Register sweep after halt
    initial begin
        forever begin
            wait (compare_req);
            for (int k = 0; k < 32; k++) begin
                @(negedge i_clk);
                i_reg_sel = 5'(k);
                @(posedge i_clk);
                check_reg(cur_name, k, exp_regs[k], o_reg_data);
            end
            check_pc(cur_name, exp_pc, o_pc);
            if (!o_halted) begin
                other_errors++;
                $display("%s: halted flag dropped after the core halted", cur_name);
            end
            compare_req = 1'b0;
        end
    end

    initial begin
        i_reset     = 1'b1;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        i_reg_sel   = '0;
        compare_req = 1'b0;
        mismatches  = 0;
        other_errors = 0;
        cycles      = 0;
        cycle_limit = 0;
        void'($urandom(32'h77e1));
        build_programs();
        for (int t = 0; t < NUM_TESTS; t++)
            cycle_limit += 40 * lens[t];
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_name = names[t];
            @(negedge i_clk);
            i_reset = 1'b1;
            for (int i = 0; i < lens[t]; i++) begin
                i_imem_we   = 1'b1;
                i_imem_addr = IMEM_AW'(i);
                i_imem_data = progs[t][i];
                @(negedge i_clk);
            end
            i_imem_we = 1'b0;
            repeat (10) @(negedge i_clk);
            i_reset = 1'b0;
            mips_ref(t);
            while (!o_halted)
                @(posedge i_clk);
            compare_req = 1'b1;
            wait (!compare_req);
        end
        print_counts();
        if (mismatches == 0 && other_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== verification/mips_assertions.sv ====
`timescale 1ns/1ps

module mips_assertions (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_stall,
    input  logic                 i_flush,
    input  mips_pkg::fwd_sel_e   i_fwd_a,
    input  mips_pkg::fwd_sel_e   i_fwd_b,
    input  logic [4:0]           i_rs,
    input  logic [4:0]           i_rt,
    input  logic                 i_halted
);
    import mips_pkg::*;

    // A stall or a flush leaves a bubble in ID/EX
    stall_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_stall || i_flush) |=> !i_stall)
        else $error("stall raised right after a stall or a taken branch");

    zero_not_fwd_a: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_rs == '0) |-> (i_fwd_a == FWD_REG))
        else $error("register 0 forwarded on operand A");

    zero_not_fwd_b: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_rt == '0) |-> (i_fwd_b == FWD_REG))
        else $error("register 0 forwarded on operand B");

    // Halted is sticky until reset
    halted_sticky: assert property (@(posedge i_clk)
        (!$past(i_reset) && $past(i_halted)) |-> i_halted)
        else $error("halted flag fell without reset");

endmodule

bind mips_top mips_assertions pipeline_checks (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_stall (stall),
    .i_flush (branch_taken),
    .i_fwd_a (mips_execute_inst.fwd_a_sel),
    .i_fwd_b (mips_execute_inst.fwd_b_sel),
    .i_rs    (id_ex_rs),
    .i_rt    (id_ex_rt),
    .i_halted(o_halted)
);

// ==== source/mips_top.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_top (
    input  logic                                 i_clk,
    input  logic                                 i_reset,
    input  logic                                 i_imem_we,
    input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0]  i_imem_addr,
    input  logic [`MIPS_XLEN-1:0]                i_imem_data,
    input  logic [`MIPS_REG_BITS-1:0]            i_reg_sel,
    output logic [`MIPS_XLEN-1:0]                o_pc,
    output logic [`MIPS_XLEN-1:0]                o_reg_data,
    output logic                                 o_halted
);
    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0]     if_id_instr, if_id_pc4;
    logic                      stall, halt_seen, branch_taken;
    logic [`MIPS_XLEN-1:0]     branch_target;

    logic [`MIPS_XLEN-1:0]     id_ex_rs_data, id_ex_rt_data, id_ex_imm, id_ex_pc4;
    logic [`MIPS_REG_BITS-1:0] id_ex_rs, id_ex_rt, id_ex_dst, id_ex_shamt;
    alu_class_e                id_ex_alu_class;
    funct_e                    id_ex_funct;
    logic id_ex_alu_src, id_ex_mem_read, id_ex_mem_write, id_ex_reg_write;
    logic id_ex_mem_to_reg, id_ex_branch, id_ex_halt;

    logic [`MIPS_XLEN-1:0]     ex_mem_alu, ex_mem_store_data, ex_mem_target;
    logic [`MIPS_REG_BITS-1:0] ex_mem_dst;
    logic ex_mem_zero, ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write;
    logic ex_mem_mem_to_reg, ex_mem_branch, ex_mem_halt;

    logic                      wb_we;
    logic [`MIPS_REG_BITS-1:0] wb_addr;
    logic [`MIPS_XLEN-1:0]     wb_data;

    mips_fetch mips_fetch_inst (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_stall         (stall),
        .i_halt_seen     (halt_seen),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .i_flush         (branch_taken),
        .o_pc            (o_pc),
        .o_instr         (if_id_instr),
        .o_pc4           (if_id_pc4)
    );

    mips_decode mips_decode_inst (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_instr         (if_id_instr),
        .i_pc4           (if_id_pc4),
        .i_flush         (branch_taken),
        .i_wb_we         (wb_we),
        .i_wb_addr       (wb_addr),
        .i_wb_data       (wb_data),
        .i_reg_sel       (i_reg_sel),
        .i_idex_mem_read (id_ex_mem_read),
        .i_idex_dst      (id_ex_dst),
        .o_stall         (stall),
        .o_halt_seen     (halt_seen),
        .o_reg_data      (o_reg_data),
        .o_rs_data       (id_ex_rs_data),
        .o_rt_data       (id_ex_rt_data),
        .o_imm           (id_ex_imm),
        .o_rs            (id_ex_rs),
        .o_rt            (id_ex_rt),
        .o_dst           (id_ex_dst),
        .o_alu_class     (id_ex_alu_class),
        .o_funct         (id_ex_funct),
        .o_shamt         (id_ex_shamt),
        .o_alu_src       (id_ex_alu_src),
        .o_mem_read      (id_ex_mem_read),
        .o_mem_write     (id_ex_mem_write),
        .o_reg_write     (id_ex_reg_write),
        .o_mem_to_reg    (id_ex_mem_to_reg),
        .o_branch        (id_ex_branch),
        .o_halt          (id_ex_halt),
        .o_pc4           (id_ex_pc4)
    );

    mips_execute mips_execute_inst (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_flush         (branch_taken),
        .i_rs_data       (id_ex_rs_data),
        .i_rt_data       (id_ex_rt_data),
        .i_imm           (id_ex_imm),
        .i_rs            (id_ex_rs),
        .i_rt            (id_ex_rt),
        .i_dst           (id_ex_dst),
        .i_alu_class     (id_ex_alu_class),
        .i_funct         (id_ex_funct),
        .i_shamt         (id_ex_shamt),
        .i_alu_src       (id_ex_alu_src),
        .i_mem_read      (id_ex_mem_read),
        .i_mem_write     (id_ex_mem_write),
        .i_reg_write     (id_ex_reg_write),
        .i_mem_to_reg    (id_ex_mem_to_reg),
        .i_branch        (id_ex_branch),
        .i_halt          (id_ex_halt),
        .i_pc4           (id_ex_pc4),
        .i_exmem_we      (ex_mem_reg_write),
        .i_exmem_dst     (ex_mem_dst),
        .i_exmem_value   (ex_mem_alu),
        .i_memwb_we      (wb_we),
        .i_memwb_dst     (wb_addr),
        .i_memwb_value   (wb_data),
        .o_alu           (ex_mem_alu),
        .o_store_data    (ex_mem_store_data),
        .o_dst           (ex_mem_dst),
        .o_zero          (ex_mem_zero),
        .o_branch_target (ex_mem_target),
        .o_mem_read      (ex_mem_mem_read),
        .o_mem_write     (ex_mem_mem_write),
        .o_reg_write     (ex_mem_reg_write),
        .o_mem_to_reg    (ex_mem_mem_to_reg),
        .o_branch        (ex_mem_branch),
        .o_halt          (ex_mem_halt)
    );

    mips_memory mips_memory_inst (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_alu           (ex_mem_alu),
        .i_store_data    (ex_mem_store_data),
        .i_dst           (ex_mem_dst),
        .i_zero          (ex_mem_zero),
        .i_branch_target (ex_mem_target),
        .i_mem_read      (ex_mem_mem_read),
        .i_mem_write     (ex_mem_mem_write),
        .i_reg_write     (ex_mem_reg_write),
        .i_mem_to_reg    (ex_mem_mem_to_reg),
        .i_branch        (ex_mem_branch),
        .i_halt          (ex_mem_halt),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target),
        .o_wb_we         (wb_we),
        .o_wb_addr       (wb_addr),
        .o_wb_data       (wb_data),
        .o_halted        (o_halted)
    );

endmodule

// ==== source/mips_memory.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_memory (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic [`MIPS_XLEN-1:0]      i_alu,
    input  logic [`MIPS_XLEN-1:0]      i_store_data,
    input  logic [`MIPS_REG_BITS-1:0]  i_dst,
    input  logic                       i_zero,
    input  logic [`MIPS_XLEN-1:0]      i_branch_target,
    input  logic                       i_mem_read,
    input  logic                       i_mem_write,
    input  logic                       i_reg_write,
    input  logic                       i_mem_to_reg,
    input  logic                       i_branch,
    input  logic                       i_halt,
    output logic                       o_branch_taken,
    output logic [`MIPS_XLEN-1:0]      o_branch_target,
    output logic                       o_wb_we,
    output logic [`MIPS_REG_BITS-1:0]  o_wb_addr,
    output logic [`MIPS_XLEN-1:0]      o_wb_data,
    output logic                       o_halted
);
    localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);

    logic [`MIPS_XLEN-1:0] dmem [`MIPS_DMEM_WORDS];
    logic [DMEM_AW-1:0]    word;
    logic [`MIPS_XLEN-1:0] alu_q, load_q;
    logic                  mem_to_reg_q, halt_q;

    assign word            = i_alu[DMEM_AW+1:2];
    assign o_branch_taken  = i_branch && i_zero;
    assign o_branch_target = i_branch_target;

    always_ff @(posedge i_clk) begin
        if (i_mem_write)
            dmem[word] <= i_store_data;
    end

    // MEM/WB
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_we      <= 1'b0;
            mem_to_reg_q <= 1'b0;
            halt_q       <= 1'b0;
        end else begin
            o_wb_we      <= i_reg_write;
            mem_to_reg_q <= i_mem_to_reg;
            halt_q       <= i_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        alu_q     <= i_alu;
        o_wb_addr <= i_dst;
        if (i_mem_read)
            load_q <= dmem[word];
    end

    assign o_wb_data = mem_to_reg_q ? load_q : alu_q;

    // Set once halt leaves MEM/WB, held until reset
    always_ff @(posedge i_clk) begin
        if (i_reset)
            o_halted <= 1'b0;
        else if (halt_q)
            o_halted <= 1'b1;
    end

endmodule

// ==== source/mips_execute.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_execute (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_flush,
    input  logic [`MIPS_XLEN-1:0]      i_rs_data,
    input  logic [`MIPS_XLEN-1:0]      i_rt_data,
    input  logic [`MIPS_XLEN-1:0]      i_imm,
    input  logic [`MIPS_REG_BITS-1:0]  i_rs,
    input  logic [`MIPS_REG_BITS-1:0]  i_rt,
    input  logic [`MIPS_REG_BITS-1:0]  i_dst,
    input  mips_pkg::alu_class_e       i_alu_class,
    input  mips_pkg::funct_e           i_funct,
    input  logic [`MIPS_REG_BITS-1:0]  i_shamt,
    input  logic                       i_alu_src,
    input  logic                       i_mem_read,
    input  logic                       i_mem_write,
    input  logic                       i_reg_write,
    input  logic                       i_mem_to_reg,
    input  logic                       i_branch,
    input  logic                       i_halt,
    input  logic [`MIPS_XLEN-1:0]      i_pc4,
    input  logic                       i_exmem_we,
    input  logic [`MIPS_REG_BITS-1:0]  i_exmem_dst,
    input  logic [`MIPS_XLEN-1:0]      i_exmem_value,
    input  logic                       i_memwb_we,
    input  logic [`MIPS_REG_BITS-1:0]  i_memwb_dst,
    input  logic [`MIPS_XLEN-1:0]      i_memwb_value,
    output logic [`MIPS_XLEN-1:0]      o_alu,
    output logic [`MIPS_XLEN-1:0]      o_store_data,
    output logic [`MIPS_REG_BITS-1:0]  o_dst,
    output logic                       o_zero,
    output logic [`MIPS_XLEN-1:0]      o_branch_target,
    output logic                       o_mem_read,
    output logic                       o_mem_write,
    output logic                       o_reg_write,
    output logic                       o_mem_to_reg,
    output logic                       o_branch,
    output logic                       o_halt
);
    import mips_pkg::*;

    fwd_sel_e              fwd_a_sel, fwd_b_sel;
    alu_op_e               alu_op;
    logic [`MIPS_XLEN-1:0] op_a, op_b_reg, op_b, result;

    // Youngest producer first
    // Writes to register 0 never carry a write enable
    function automatic fwd_sel_e fwd_pick(input logic [`MIPS_REG_BITS-1:0] src);
        if (i_exmem_we && i_exmem_dst == src)
            return FWD_EXMEM;
        if (i_memwb_we && i_memwb_dst == src)
            return FWD_MEMWB;
        return FWD_REG;
    endfunction

    function automatic logic [`MIPS_XLEN-1:0] fwd_value(input fwd_sel_e sel,
                                                        input logic [`MIPS_XLEN-1:0] reg_val);
        case (sel)
            FWD_EXMEM: return i_exmem_value;
            FWD_MEMWB: return i_memwb_value;
            default:   return reg_val;
        endcase
    endfunction

    assign fwd_a_sel = fwd_pick(i_rs);
    assign fwd_b_sel = fwd_pick(i_rt);
    assign op_a      = fwd_value(fwd_a_sel, i_rs_data);
    assign op_b_reg  = fwd_value(fwd_b_sel, i_rt_data);
    assign op_b      = i_alu_src ? i_imm : op_b_reg;

    always_comb begin
        case (i_alu_class)
            CLS_SUB: alu_op = ALU_SUB;
            CLS_FUNCT: begin
                case (i_funct)
                    F_SLL:   alu_op = ALU_SLL;
                    F_SUBU:  alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_SLT:   alu_op = ALU_SLT;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            // sll shifts rt
            ALU_SLL: result = op_b << i_shamt;
            default: result = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_reg_write  <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_branch     <= 1'b0;
            o_halt       <= 1'b0;
        end else begin
            o_mem_read   <= i_mem_read;
            o_mem_write  <= i_mem_write;
            o_reg_write  <= i_reg_write;
            o_mem_to_reg <= i_mem_to_reg;
            o_branch     <= i_branch;
            o_halt       <= i_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        o_alu           <= result;
        o_store_data    <= op_b_reg;
        o_dst           <= i_dst;
        o_zero          <= (result == '0);
        o_branch_target <= i_pc4 + (i_imm << 2);
    end

endmodule

// ==== source/mips_decode.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_decode (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic [`MIPS_XLEN-1:0]      i_instr,
    input  logic [`MIPS_XLEN-1:0]      i_pc4,
    input  logic                       i_flush,
    input  logic                       i_wb_we,
    input  logic [`MIPS_REG_BITS-1:0]  i_wb_addr,
    input  logic [`MIPS_XLEN-1:0]      i_wb_data,
    input  logic [`MIPS_REG_BITS-1:0]  i_reg_sel,
    input  logic                       i_idex_mem_read,
    input  logic [`MIPS_REG_BITS-1:0]  i_idex_dst,
    output logic                       o_stall,
    output logic                       o_halt_seen,
    output logic [`MIPS_XLEN-1:0]      o_reg_data,
    output logic [`MIPS_XLEN-1:0]      o_rs_data,
    output logic [`MIPS_XLEN-1:0]      o_rt_data,
    output logic [`MIPS_XLEN-1:0]      o_imm,
    output logic [`MIPS_REG_BITS-1:0]  o_rs,
    output logic [`MIPS_REG_BITS-1:0]  o_rt,
    output logic [`MIPS_REG_BITS-1:0]  o_dst,
    output mips_pkg::alu_class_e       o_alu_class,
    output mips_pkg::funct_e           o_funct,
    output logic [`MIPS_REG_BITS-1:0]  o_shamt,
    output logic                       o_alu_src,
    output logic                       o_mem_read,
    output logic                       o_mem_write,
    output logic                       o_reg_write,
    output logic                       o_mem_to_reg,
    output logic                       o_branch,
    output logic                       o_halt,
    output logic [`MIPS_XLEN-1:0]      o_pc4
);
    import mips_pkg::*;

    localparam int NUM_REGS = 1 << `MIPS_REG_BITS;

    logic [`MIPS_XLEN-1:0]     regs [NUM_REGS];
    opcode_e                   opcode;
    logic [`MIPS_REG_BITS-1:0] rs, rt, rd, dst;
    logic [`MIPS_XLEN-1:0]     imm;
    alu_class_e                ctl_class;
    logic ctl_alu_src, ctl_mem_read, ctl_mem_write, ctl_reg_write;
    logic ctl_mem_to_reg, ctl_branch, ctl_halt;
    logic halt_q;
    logic hazard;

    // Register 0 reads zero, writeback passes straight through
    function automatic logic [`MIPS_XLEN-1:0] read_reg(input logic [`MIPS_REG_BITS-1:0] addr);
        if (addr == '0)
            return '0;
        if (i_wb_we && i_wb_addr == addr)
            return i_wb_data;
        return regs[addr];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_wb_we && i_wb_addr != '0)
            regs[i_wb_addr] <= i_wb_data;
    end

    assign opcode     = opcode_e'(i_instr[`MIPS_OP_MSB -: $bits(opcode_e)]);
    assign rs         = i_instr[`MIPS_RS_LSB +: `MIPS_REG_BITS];
    assign rt         = i_instr[`MIPS_RT_LSB +: `MIPS_REG_BITS];
    assign rd         = i_instr[`MIPS_RD_LSB +: `MIPS_REG_BITS];
    assign dst        = (opcode == OP_RTYPE) ? rd : rt;
    assign imm        = {{(`MIPS_XLEN-`MIPS_IMM_BITS){i_instr[`MIPS_IMM_BITS-1]}},
                         i_instr[`MIPS_IMM_BITS-1:0]};
    assign o_reg_data = read_reg(i_reg_sel);

    always_comb begin
        ctl_class      = CLS_ADD;
        ctl_alu_src    = 1'b0;
        ctl_mem_read   = 1'b0;
        ctl_mem_write  = 1'b0;
        ctl_reg_write  = 1'b0;
        ctl_mem_to_reg = 1'b0;
        ctl_branch     = 1'b0;
        ctl_halt       = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctl_class     = CLS_FUNCT;
                ctl_reg_write = 1'b1;
            end
            OP_ADDI: begin
                ctl_alu_src   = 1'b1;
                ctl_reg_write = 1'b1;
            end
            OP_LW: begin
                ctl_alu_src    = 1'b1;
                ctl_mem_read   = 1'b1;
                ctl_reg_write  = 1'b1;
                ctl_mem_to_reg = 1'b1;
            end
            OP_SW: begin
                ctl_alu_src   = 1'b1;
                ctl_mem_write = 1'b1;
            end
            OP_BEQ: begin
                ctl_class  = CLS_SUB;
                ctl_branch = 1'b1;
            end
            OP_HALT: ctl_halt = 1'b1;
            default: ;
        endcase
    end

    // Load in ID/EX feeding this instruction
    assign hazard      = i_idex_mem_read && i_idex_dst != '0 &&
                         (i_idex_dst == rs || i_idex_dst == rt);
    assign o_stall     = hazard && !i_flush;
    assign o_halt_seen = halt_q || ctl_halt;

    // Halt stays seen unless an older branch annuls it
    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush)
            halt_q <= 1'b0;
        else if (ctl_halt)
            halt_q <= 1'b1;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush || hazard) begin
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_reg_write  <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_branch     <= 1'b0;
            o_halt       <= 1'b0;
        end else begin
            o_mem_read   <= ctl_mem_read;
            o_mem_write  <= ctl_mem_write;
            o_reg_write  <= ctl_reg_write && dst != '0;
            o_mem_to_reg <= ctl_mem_to_reg;
            o_branch     <= ctl_branch;
            o_halt       <= ctl_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        o_rs_data   <= read_reg(rs);
        o_rt_data   <= read_reg(rt);
        o_imm       <= imm;
        o_rs        <= rs;
        o_rt        <= rt;
        o_dst       <= dst;
        o_alu_class <= ctl_class;
        o_funct     <= funct_e'(i_instr[5:0]);
        o_shamt     <= i_instr[`MIPS_SHAMT_LSB +: `MIPS_REG_BITS];
        o_alu_src   <= ctl_alu_src;
        o_pc4       <= i_pc4;
    end

endmodule

// ==== source/mips_fetch.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_fetch (
    input  logic                                 i_clk,
    input  logic                                 i_reset,
    input  logic                                 i_stall,
    input  logic                                 i_halt_seen,
    input  logic                                 i_branch_taken,
    input  logic [`MIPS_XLEN-1:0]                i_branch_target,
    input  logic                                 i_imem_we,
    input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0]  i_imem_addr,
    input  logic [`MIPS_XLEN-1:0]                i_imem_data,
    input  logic                                 i_flush,
    output logic [`MIPS_XLEN-1:0]                o_pc,
    output logic [`MIPS_XLEN-1:0]                o_instr,
    output logic [`MIPS_XLEN-1:0]                o_pc4
);
    localparam int IMEM_AW = $clog2(`MIPS_IMEM_WORDS);

    logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_WORDS];
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pc4;

    assign pc4  = pc + 32'd4;
    assign o_pc = pc;

    // Load port, word addressed
    always_ff @(posedge i_clk) begin
        if (i_imem_we)
            imem[i_imem_addr] <= i_imem_data;
    end

    // Branch wins over stall and halt
    always_ff @(posedge i_clk) begin
        if (i_reset)
            pc <= '0;
        else if (i_branch_taken)
            pc <= i_branch_target;
        else if (!i_stall && !i_halt_seen)
            pc <= pc4;
    end

    // IF/ID, zero word is a nop
    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            o_instr <= '0;
        end else if (!i_stall) begin
            o_instr <= i_halt_seen ? '0 : imem[pc[IMEM_AW+1:2]];
            o_pc4   <= pc4;
        end
    end

endmodule

// ==== source/mips_pkg.sv ====
package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL
    } alu_op_e;

    // Coarse ALU class chosen in decode, refined by funct in execute
    typedef enum logic [1:0] {
        CLS_ADD,
        CLS_SUB,
        CLS_FUNCT
    } alu_class_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

endpackage

// ==== include/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath and register file
`define MIPS_XLEN        32
`define MIPS_REG_BITS    5

// Memory depths in words
`define MIPS_IMEM_WORDS  64
`define MIPS_DMEM_WORDS  64

// Instruction fields
`define MIPS_OP_MSB      31
`define MIPS_RS_LSB      21
`define MIPS_RT_LSB      16
`define MIPS_RD_LSB      11
`define MIPS_SHAMT_LSB   6
`define MIPS_IMM_BITS    16

`endif
